//--- common/vip_pkg.sv
package vip_pkg;

	// ------------------------------------------------------------------------
	// plain vector types
	// ------------------------------------------------------------------------
	typedef logic [7:0]         pix_t;        // colour or luma sample
	typedef logic [10:0]        coord_t;      // pixel or line index
	typedef logic [15:0]        pix_count_t;  // pixels per frame
	typedef logic signed [9:0]  coef_t;       // 1/256 units
	typedef logic signed [8:0]  chroma_t;     // centred cb/cr
	typedef logic signed [17:0] mult_t;       // sample times coefficient
	typedef logic signed [19:0] acc_t;        // product sums

	// ------------------------------------------------------------------------
	// frame geometry, counted in pixel enables and lines
	// ------------------------------------------------------------------------
	localparam coord_t H_SYNC   = 11'd10;
	localparam coord_t H_BACK   = 11'd10;
	localparam coord_t H_ACTIVE = 11'd64;
	localparam coord_t H_FRONT  = 11'd10;
	localparam coord_t H_TOTAL  = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;  // 94
	localparam coord_t H_START  = H_SYNC + H_BACK;

	localparam coord_t V_SYNC   = 11'd10;
	localparam coord_t V_BACK   = 11'd10;
	localparam coord_t V_ACTIVE = 11'd48;
	localparam coord_t V_FRONT  = 11'd10;
	localparam coord_t V_TOTAL  = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;  // 78
	localparam coord_t V_START  = V_SYNC + V_BACK;

	localparam pix_count_t FRAME_PIXELS = H_ACTIVE * V_ACTIVE;

	// ------------------------------------------------------------------------
	// colour conversion
	// ------------------------------------------------------------------------
	localparam pix_t LUMA_LIFT  = 8'd30;   // added to y on the lift branch
	localparam acc_t CHROMA_OFS = 20'sd128;

	// forward, rgb to ycbcr
	localparam coef_t COEF_Y_R  =  10'sd77;
	localparam coef_t COEF_Y_G  =  10'sd150;
	localparam coef_t COEF_Y_B  =  10'sd29;
	localparam coef_t COEF_CB_R = -10'sd43;
	localparam coef_t COEF_CB_G = -10'sd85;
	localparam coef_t COEF_CB_B =  10'sd128;
	localparam coef_t COEF_CR_R =  10'sd128;
	localparam coef_t COEF_CR_G = -10'sd107;
	localparam coef_t COEF_CR_B = -10'sd21;

	// back, ycbcr to rgb on centred chroma
	localparam coef_t COEF_R_CR =  10'sd359;
	localparam coef_t COEF_G_CB =  10'sd88;
	localparam coef_t COEF_G_CR =  10'sd183;
	localparam coef_t COEF_B_CB =  10'sd454;

	// ------------------------------------------------------------------------
	// stream structs
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic vsync;  // low during the vertical sync lines
		logic href;   // active window
		logic de;     // href on the half-rate enable
	} video_sync_t;

	typedef struct packed {
		pix_t r;
		pix_t g;
		pix_t b;
	} rgb_pix_t;

	typedef struct packed {
		pix_t y;
		pix_t cb;
		pix_t cr;
	} ycbcr_pix_t;

	typedef struct packed {
		video_sync_t sync;
		rgb_pix_t    pix;
	} video_rgb_t;

	typedef struct packed {
		video_sync_t sync;
		ycbcr_pix_t  pix;
	} video_ycbcr_t;

	typedef struct packed {
		video_sync_t sync;
		pix_t        grey;
		rgb_pix_t    lift;
	} vip_out_t;

endpackage

//--- source/video_timing_gen.sv
`timescale 1ns/10ps

module video_timing_gen (
	input  logic                 clk,
	input  logic                 rst_n,
	output logic                 o_rd_en,
	output vip_pkg::coord_t      o_rd_x,
	output vip_pkg::coord_t      o_rd_y,
	output vip_pkg::video_sync_t o_sync
);

	logic                 pix_en;  // half-rate pixel enable
	vip_pkg::coord_t      h_cnt;
	vip_pkg::coord_t      v_cnt;
	logic                 window;
	logic                 h_last;
	vip_pkg::video_sync_t sync_q;  // sync of the request cycle

	// ------------------------------------------------------------------------
	// pixel enable and counters
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pix_en <= 1'b0;
		else
			pix_en <= ~pix_en;
	end

	assign h_last = (h_cnt == vip_pkg::H_TOTAL - 1'b1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (pix_en) begin
			h_cnt <= h_last ? '0 : h_cnt + 1'b1;
			if (h_last)
				v_cnt <= (v_cnt == vip_pkg::V_TOTAL - 1'b1) ? '0 : v_cnt + 1'b1;
		end
	end

	// active window, decoded straight from the counters
	assign window = (v_cnt >= vip_pkg::V_START) &&
			(v_cnt <  vip_pkg::V_START + vip_pkg::V_ACTIVE) &&
			(h_cnt >= vip_pkg::H_START) &&
			(h_cnt <  vip_pkg::H_START + vip_pkg::H_ACTIVE);

	// ------------------------------------------------------------------------
	// read request, then the sync one cycle later to meet the fetched pixel
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= '0;
			o_rd_x <= '0;
			o_rd_y <= '0;
			o_sync <= '0;
		end else begin
			sync_q.vsync <= (v_cnt >= vip_pkg::V_SYNC);
			sync_q.href  <= window;
			sync_q.de    <= window & pix_en;  // once per counter value
			o_rd_x       <= window ? h_cnt - vip_pkg::H_START : '0;
			o_rd_y       <= window ? v_cnt - vip_pkg::V_START : '0;
			o_sync       <= sync_q;
		end
	end

	assign o_rd_en = sync_q.de;

	// a request lies inside the image
	assert property (@(posedge clk) disable iff (!rst_n)
		o_rd_en |-> ((o_rd_x < vip_pkg::H_ACTIVE) && (o_rd_y < vip_pkg::V_ACTIVE)));

endmodule

//--- color_convert/rgb_to_ycbcr.sv
`timescale 1ns/10ps

module rgb_to_ycbcr (
	input  logic                  clk,
	input  logic                  rst_n,
	input  vip_pkg::video_rgb_t   i_video,
	output vip_pkg::video_ycbcr_t o_video
);

	logic signed [8:0]    r_s;
	logic signed [8:0]    g_s;
	logic signed [8:0]    b_s;
	vip_pkg::mult_t       y_p  [3];  // r, g, b products
	vip_pkg::mult_t       cb_p [3];
	vip_pkg::mult_t       cr_p [3];
	vip_pkg::acc_t        y_sum;
	vip_pkg::acc_t        cb_sum;
	vip_pkg::acc_t        cr_sum;
	vip_pkg::ycbcr_pix_t  pix_q;
	vip_pkg::video_sync_t sync_d [3];

	// samples as positive signed values
	assign r_s = $signed({1'b0, i_video.pix.r});
	assign g_s = $signed({1'b0, i_video.pix.g});
	assign b_s = $signed({1'b0, i_video.pix.b});

	// ------------------------------------------------------------------------
	// stage 1 products, stage 2 sums, stage 3 shift and offset
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		y_p[0]  <= r_s * vip_pkg::COEF_Y_R;
		y_p[1]  <= g_s * vip_pkg::COEF_Y_G;
		y_p[2]  <= b_s * vip_pkg::COEF_Y_B;
		cb_p[0] <= r_s * vip_pkg::COEF_CB_R;
		cb_p[1] <= g_s * vip_pkg::COEF_CB_G;
		cb_p[2] <= b_s * vip_pkg::COEF_CB_B;
		cr_p[0] <= r_s * vip_pkg::COEF_CR_R;
		cr_p[1] <= g_s * vip_pkg::COEF_CR_G;
		cr_p[2] <= b_s * vip_pkg::COEF_CR_B;

		y_sum  <= y_p[0] + y_p[1] + y_p[2];
		cb_sum <= cb_p[0] + cb_p[1] + cb_p[2];
		cr_sum <= cr_p[0] + cr_p[1] + cr_p[2];

		// floor shift keeps every result inside 0..255
		pix_q.y  <= vip_pkg::pix_t'(y_sum >>> 8);
		pix_q.cb <= vip_pkg::pix_t'((cb_sum >>> 8) + vip_pkg::CHROMA_OFS);
		pix_q.cr <= vip_pkg::pix_t'((cr_sum >>> 8) + vip_pkg::CHROMA_OFS);
	end

	// sync follows the data through three registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_d[0] <= '0;
			sync_d[1] <= '0;
			sync_d[2] <= '0;
		end else begin
			sync_d[0] <= i_video.sync;
			sync_d[1] <= sync_d[0];
			sync_d[2] <= sync_d[1];
		end
	end

	assign o_video = '{sync: sync_d[2], pix: pix_q};

endmodule

//--- color_convert/ycbcr_to_rgb.sv
`timescale 1ns/10ps

module ycbcr_to_rgb (
	input  logic                  clk,
	input  logic                  rst_n,
	input  vip_pkg::video_ycbcr_t i_video,
	output vip_pkg::video_rgb_t   o_video
);

	logic [8:0]           lift_sum;   // y plus offset, one carry bit
	vip_pkg::pix_t        y_s1;
	vip_pkg::chroma_t     cb_c;
	vip_pkg::chroma_t     cr_c;
	vip_pkg::pix_t        y_s2;
	vip_pkg::mult_t       r_cr_p;
	vip_pkg::mult_t       g_cb_p;
	vip_pkg::mult_t       g_cr_p;
	vip_pkg::mult_t       b_cb_p;
	vip_pkg::acc_t        r_sum;
	vip_pkg::acc_t        g_sum;
	vip_pkg::acc_t        b_sum;
	vip_pkg::rgb_pix_t    pix_q;
	vip_pkg::video_sync_t sync_d [3];

	function automatic vip_pkg::pix_t clamp_pix(input vip_pkg::acc_t v);
		if (v < 0)
			return '0;
		else if (v > 255)
			return 8'hff;
		else
			return v[7:0];
	endfunction

	assign lift_sum = {1'b0, i_video.pix.y} + {1'b0, vip_pkg::LUMA_LIFT};

	// ------------------------------------------------------------------------
	// stage 1: lift and centre
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		y_s1 <= lift_sum[8] ? 8'hff : lift_sum[7:0];  // saturate, no wrap
		cb_c <= vip_pkg::chroma_t'(vip_pkg::acc_t'(i_video.pix.cb) - vip_pkg::CHROMA_OFS);
		cr_c <= vip_pkg::chroma_t'(vip_pkg::acc_t'(i_video.pix.cr) - vip_pkg::CHROMA_OFS);
	end

	// ------------------------------------------------------------------------
	// stage 2: chroma products
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		y_s2   <= y_s1;
		r_cr_p <= cr_c * vip_pkg::COEF_R_CR;
		g_cb_p <= cb_c * vip_pkg::COEF_G_CB;
		g_cr_p <= cr_c * vip_pkg::COEF_G_CR;
		b_cb_p <= cb_c * vip_pkg::COEF_B_CB;
	end

	// stage 3 sums, green takes the shift of the summed products
	assign r_sum = vip_pkg::acc_t'(y_s2) + (vip_pkg::acc_t'(r_cr_p) >>> 8);
	assign g_sum = vip_pkg::acc_t'(y_s2) -
		((vip_pkg::acc_t'(g_cb_p) + vip_pkg::acc_t'(g_cr_p)) >>> 8);
	assign b_sum = vip_pkg::acc_t'(y_s2) + (vip_pkg::acc_t'(b_cb_p) >>> 8);

	always_ff @(posedge clk) begin
		pix_q.r <= clamp_pix(r_sum);
		pix_q.g <= clamp_pix(g_sum);
		pix_q.b <= clamp_pix(b_sum);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_d[0] <= '0;
			sync_d[1] <= '0;
			sync_d[2] <= '0;
		end else begin
			sync_d[0] <= i_video.sync;
			sync_d[1] <= sync_d[0];
			sync_d[2] <= sync_d[1];
		end
	end

	assign o_video = '{sync: sync_d[2], pix: pix_q};

endmodule

//--- source/frame_merge.sv
`timescale 1ns/10ps

module frame_merge (
	input  logic                  clk,
	input  logic                  rst_n,
	input  vip_pkg::video_ycbcr_t i_luma,
	input  vip_pkg::video_rgb_t   i_lift,
	output vip_pkg::vip_out_t     o_out,
	output logic                  o_frame_done,
	output vip_pkg::pix_count_t   o_frame_pixels
);

	vip_pkg::video_sync_t grey_sync [3];
	vip_pkg::pix_t        grey_y    [3];
	vip_pkg::video_sync_t out_sync;
	vip_pkg::pix_t        out_grey;
	vip_pkg::rgb_pix_t    out_lift;
	logic                 vsync_last;
	logic                 vsync_fall;
	vip_pkg::pix_count_t  pix_cnt;

	// ------------------------------------------------------------------------
	// grey branch, y delayed to match the back converter
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grey_sync[0] <= '0;
			grey_sync[1] <= '0;
			grey_sync[2] <= '0;
		end else begin
			grey_sync[0] <= i_luma.sync;
			grey_sync[1] <= grey_sync[0];
			grey_sync[2] <= grey_sync[1];
		end
	end

	always_ff @(posedge clk) begin
		grey_y[0] <= i_luma.pix.y;
		grey_y[1] <= grey_y[0];
		grey_y[2] <= grey_y[1];
	end

	// output register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_sync <= '0;
		else
			out_sync <= i_lift.sync;
	end

	always_ff @(posedge clk) begin
		out_grey <= grey_y[2];
		out_lift <= i_lift.pix;
	end

	assign o_out = '{sync: out_sync, grey: out_grey, lift: out_lift};

	// ------------------------------------------------------------------------
	// per-frame pixel count
	// ------------------------------------------------------------------------
	assign vsync_fall = vsync_last & ~i_lift.sync.vsync;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vsync_last     <= 1'b1;  // reset counts as a frame boundary
			pix_cnt        <= '0;
			o_frame_done   <= 1'b0;
			o_frame_pixels <= '0;
		end else begin
			vsync_last   <= i_lift.sync.vsync;
			o_frame_done <= vsync_fall;  // lines up with the o_out fall
			if (vsync_fall) begin
				o_frame_pixels <= pix_cnt;
				pix_cnt        <= '0;
			end else if (i_lift.sync.de) begin
				pix_cnt <= pix_cnt + 1'b1;
			end
		end
	end

	// both branches leave the front converter together and must stay aligned
	assert property (@(posedge clk) disable iff (!rst_n)
		grey_sync[2] == i_lift.sync);

endmodule

//--- source/vip_enhance_top.sv
`timescale 1ns/10ps

module vip_enhance_top (
	input  logic                clk,
	input  logic                rst_n,
	input  vip_pkg::rgb_pix_t   i_rgb,
	output logic                o_rd_en,
	output vip_pkg::coord_t     o_rd_x,
	output vip_pkg::coord_t     o_rd_y,
	output vip_pkg::vip_out_t   o_out,
	output logic                o_frame_done,
	output vip_pkg::pix_count_t o_frame_pixels
);

	vip_pkg::video_sync_t  tg_sync;
	vip_pkg::video_rgb_t   rgb_stream;    // sync joined with the fetched pixel
	vip_pkg::video_ycbcr_t ycbcr_stream;  // feeds both branches
	vip_pkg::video_rgb_t   lift_stream;

	assign rgb_stream = '{sync: tg_sync, pix: i_rgb};

	video_timing_gen timing_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.o_rd_en (o_rd_en),
		.o_rd_x  (o_rd_x),
		.o_rd_y  (o_rd_y),
		.o_sync  (tg_sync)
	);

	rgb_to_ycbcr fwd_conv_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_video (rgb_stream),
		.o_video (ycbcr_stream)
	);

	ycbcr_to_rgb lift_conv_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_video (ycbcr_stream),
		.o_video (lift_stream)
	);

	frame_merge merge_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_luma         (ycbcr_stream),
		.i_lift         (lift_stream),
		.o_out          (o_out),
		.o_frame_done   (o_frame_done),
		.o_frame_pixels (o_frame_pixels)
	);

endmodule

//--- testbench/tb_vip_enhance.sv
`timescale 1ns/10ps

module tb_vip_enhance;

	typedef enum {MODE_GREY, MODE_RANDOM, MODE_SAT} pix_mode_t;

	localparam int FRAME_CLOCKS = vip_pkg::H_TOTAL * vip_pkg::V_TOTAL * 2;  // 14664
	localparam int CYCLE_LIMIT  = 5 * FRAME_CLOCKS + 6680;                 // 80000

	logic                clk = 1'b0;
	logic                rst_n;
	vip_pkg::rgb_pix_t   i_rgb;
	logic                o_rd_en;
	vip_pkg::coord_t     o_rd_x;
	vip_pkg::coord_t     o_rd_y;
	vip_pkg::vip_out_t   o_out;
	logic                o_frame_done;
	vip_pkg::pix_count_t o_frame_pixels;

	pix_mode_t           mode = MODE_GREY;
	vip_pkg::vip_out_t   exp_q [$];      // expected grey and lift, in order
	vip_pkg::rgb_pix_t   pend_pix;       // fetched pixel, answered next cycle
	logic                pend_valid = 1'b0;
	int                  req_count = 0;
	int                  scan_idx;       // position of a request in the frame scan
	int                  rd_cnt = 0;     // requests since the last frame_done
	vip_pkg::pix_count_t done_pix [$];
	int                  done_req [$];
	int                  done_seen = 0;
	int                  cycle_cnt = 0;
	int                  errors = 0;
	int                  checks = 0;
	int                  tests = 0;

	vip_enhance_top dut_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_rgb          (i_rgb),
		.o_rd_en        (o_rd_en),
		.o_rd_x         (o_rd_x),
		.o_rd_y         (o_rd_y),
		.o_out          (o_out),
		.o_frame_done   (o_frame_done),
		.o_frame_pixels (o_frame_pixels)
	);

	always #10 clk = ~clk;

	// ------------------------------------------------------------------------
	// reference model, straight from the conversion rules
	// ------------------------------------------------------------------------
	function automatic vip_pkg::pix_t clamp_byte(input int v);
		if (v < 0)
			return 8'h00;
		if (v > 255)
			return 8'hff;
		return vip_pkg::pix_t'(v);
	endfunction

	function automatic vip_pkg::vip_out_t model_out(input vip_pkg::rgb_pix_t p);
		int r, g, b, y, cb, cr, yl;
		vip_pkg::vip_out_t o;
		r  = p.r;
		g  = p.g;
		b  = p.b;
		y  = (77 * r + 150 * g + 29 * b) >>> 8;
		cb = ((-43 * r - 85 * g + 128 * b) >>> 8) + 128;
		cr = ((128 * r - 107 * g - 21 * b) >>> 8) + 128;
		yl = y + int'(vip_pkg::LUMA_LIFT);
		if (yl > 255)
			yl = 255;  // lift saturates
		o.sync   = '0;
		o.grey   = vip_pkg::pix_t'(y);
		o.lift.r = clamp_byte(yl + ((359 * (cr - 128)) >>> 8));
		o.lift.g = clamp_byte(yl - ((88 * (cb - 128) + 183 * (cr - 128)) >>> 8));
		o.lift.b = clamp_byte(yl + ((454 * (cb - 128)) >>> 8));
		return o;
	endfunction

	function automatic vip_pkg::rgb_pix_t pixel_for(input pix_mode_t m, input int x, input int y);
		vip_pkg::pix_t v;
		case (m)
			MODE_GREY:
				v = vip_pkg::pix_t'(y * vip_pkg::H_ACTIVE + x);  // sweeps 0..255
			MODE_SAT:
				v = (x % 8 == 0) ? 8'hff : vip_pkg::pix_t'(225 + (x + 3 * y) % 31);
			default:
				return vip_pkg::rgb_pix_t'($urandom);
		endcase
		return '{r: v, g: v, b: v};
	endfunction

	// ------------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------------
	task automatic check_pix(input vip_pkg::pix_t got, input vip_pkg::pix_t exp, input string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_rgb(input vip_pkg::rgb_pix_t got, input vip_pkg::rgb_pix_t exp,
			input string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s got %6h expected %6h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input vip_pkg::pix_count_t got, input vip_pkg::pix_count_t exp,
			input string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_coord(input vip_pkg::coord_t got, input vip_pkg::coord_t exp,
			input string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_sync(input vip_pkg::video_sync_t got, input vip_pkg::video_sync_t exp,
			input string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s got %3b expected %3b", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// ------------------------------------------------------------------------
	// read port answer, output checker and frame records
	// ------------------------------------------------------------------------
	initial begin
		void'($urandom(84));
		forever begin
			@(negedge clk);
			if (pend_valid)
				i_rgb = pend_pix;  // registered fetch, one cycle after the request
			pend_valid = o_rd_en;
			if (o_rd_en) begin
				// requests scan the active window row by row
				scan_idx = req_count % vip_pkg::FRAME_PIXELS;
				check_coord(o_rd_x, vip_pkg::coord_t'(scan_idx % vip_pkg::H_ACTIVE), "o_rd_x");
				check_coord(o_rd_y, vip_pkg::coord_t'(scan_idx / vip_pkg::H_ACTIVE), "o_rd_y");
				pend_pix = pixel_for(mode, o_rd_x, o_rd_y);
				exp_q.push_back(model_out(pend_pix));
				req_count++;
				rd_cnt++;
			end
			if (o_out.sync.de) begin
				check_sync(o_out.sync, 3'b111, "o_out.sync");
				if (exp_q.size() == 0) begin
					errors++;
					$display("error at %0t ns: output pixel arrived with nothing expected",
						$time);
				end else begin
					check_pix(o_out.grey, exp_q[0].grey, "o_out.grey");
					check_rgb(o_out.lift, exp_q[0].lift, "o_out.lift");
					void'(exp_q.pop_front());
				end
			end
			if (o_frame_done) begin
				check_flag(o_out.sync.vsync, 1'b0, "o_out.sync.vsync");  // pulse on the fall
				done_pix.push_back(o_frame_pixels);
				done_req.push_back(rd_cnt);
				rd_cnt = 0;
				done_seen++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: run stopped after %0d cycles", cycle_cnt);
			$display("Regression failed");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	task automatic report_test(input string name, input int err_before);
		tests++;
		$display("%-18s %s, %0d errors", name, (errors == err_before) ? "ok" : "bad",
			errors - err_before);
	endtask

	// one frame of requests in the given mode, then the pipeline drains
	task automatic run_frame(input pix_mode_t m);
		int target;
		mode   = m;
		target = req_count + vip_pkg::FRAME_PIXELS;
		while (req_count < target)
			@(posedge clk);
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic test_reset();
		int e0;
		e0 = errors;
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_flag(o_rd_en, 1'b0, "o_rd_en");
		check_sync(o_out.sync, '0, "o_out.sync");
		check_flag(o_frame_done, 1'b0, "o_frame_done");
		check_count(o_frame_pixels, '0, "o_frame_pixels");
		rst_n = 1'b1;
		report_test("reset state", e0);
	endtask

	task automatic test_grey_sweep();
		int e0;
		e0 = errors;
		run_frame(MODE_GREY);
		report_test("grey sweep", e0);
	endtask

	task automatic test_random_frame();
		int e0;
		e0 = errors;
		run_frame(MODE_RANDOM);
		report_test("random frame", e0);
	endtask

	task automatic test_saturation();
		int e0;
		e0 = errors;
		run_frame(MODE_SAT);  // every lift channel ends at ff
		report_test("saturation", e0);
	endtask

	task automatic test_frame_accounting();
		int e0;
		int start;
		e0    = errors;
		mode  = MODE_RANDOM;
		start = done_seen;
		while (done_seen < start + 2)
			@(posedge clk);
		// first pulse after reset comes before any pixel
		check_count(done_pix[0], '0, "o_frame_pixels first");
		check_count(vip_pkg::pix_count_t'(done_req[0]), '0, "o_rd_en first");
		for (int i = start; i < start + 2; i++) begin
			check_count(done_pix[i], vip_pkg::FRAME_PIXELS, "o_frame_pixels");
			check_count(vip_pkg::pix_count_t'(done_req[i]), vip_pkg::FRAME_PIXELS, "o_rd_en pulses");
		end
		while (exp_q.size() != 0)
			@(posedge clk);
		report_test("frame accounting", e0);
	endtask

	initial begin
		rst_n = 1'b0;
		i_rgb = '0;
		test_reset();
		test_grey_sweep();
		test_random_frame();
		test_saturation();
		test_frame_accounting();
		if (exp_q.size() != 0) begin
			errors++;
			$display("error: %0d expected pixels never came out", exp_q.size());
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- files.f
common/vip_pkg.sv
source/video_timing_gen.sv
color_convert/rgb_to_ycbcr.sv
color_convert/ycbcr_to_rgb.sv
source/frame_merge.sv
source/vip_enhance_top.sv
testbench/tb_vip_enhance.sv

//--- Bender.yml
package:
  name: vip_enhance

sources:
  - common/vip_pkg.sv
  - source/video_timing_gen.sv
  - color_convert/rgb_to_ycbcr.sv
  - color_convert/ycbcr_to_rgb.sv
  - source/frame_merge.sv
  - source/vip_enhance_top.sv
  - target: test
    files:
      - testbench/tb_vip_enhance.sv
